// File: hw/ingress_pkg.sv
/* Bus widths, port-class byte widths and counter width shared by the ingress stage.
   Modules import it where the body needs these constants. */

package ingress_pkg;

    // Converged bus
    localparam int bus_bytes = 8;
    localparam int bus_width = bus_bytes * 8;

    // Physical port classes
    localparam int port_8b_bytes  = 1;
    localparam int port_32b_bytes = 4;

    // Statistics
    localparam int cnt_width = 32;

endpackage

// File: hw/ingress_width_upsizer.sv
/* Gathers narrow physical port beats into 64-bit words, lowest byte first.
   One instance per physical port, in_bytes set by the port class. */

`timescale 1ns/1ns

module ingress_width_upsizer #(
    parameter int in_bytes = 1
) (
    input  logic                              clk_ifc,
    input  logic                              rst_n,
    input  logic                              in_valid,
    input  logic [in_bytes*8-1:0]             in_data,
    input  logic [in_bytes-1:0]               in_keep_last,
    input  logic                              in_last,
    output logic                              word_valid,
    output logic [ingress_pkg::bus_width-1:0] word_data,
    output logic [ingress_pkg::bus_bytes-1:0] word_keep,
    output logic                              word_last
);

    import ingress_pkg::*;

    localparam int beats_per_word = bus_bytes / in_bytes;
    localparam int idx_bits       = $clog2(beats_per_word);

    logic [idx_bits-1:0]  beat_idx;
    logic [bus_width-1:0] next_data;
    logic [bus_bytes-1:0] next_keep;
    logic                 word_done;

    // The output registers double as the accumulator; a new word starts from zero
    always_comb begin
        next_data = (beat_idx == '0) ? '0 : word_data;
        next_keep = (beat_idx == '0) ? '0 : word_keep;
        next_data[beat_idx*in_bytes*8 +: in_bytes*8] = in_data;
        next_keep[beat_idx*in_bytes +: in_bytes]     = in_last ? in_keep_last : '1;
    end

    assign word_done = in_last || (beat_idx == idx_bits'(beats_per_word - 1));

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx   <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= in_valid && word_done;
            if (in_valid) begin
                beat_idx <= word_done ? '0 : beat_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (in_valid) begin
            word_data <= next_data;
            word_keep <= next_keep;
            word_last <= in_last;
        end
    end

endmodule

// File: hw/ingress_pkt_fifo.sv
/* Per-port packet buffer. Words land behind a speculative pointer and become
   visible only once the whole packet is stored; overflow discards the packet. */

`timescale 1ns/1ns

module ingress_pkt_fifo #(
    parameter int fifo_words = 64
) (
    input  logic                              clk_ifc,
    input  logic                              rst_n,
    input  logic                              enable,
    input  logic                              word_valid,
    input  logic [ingress_pkg::bus_width-1:0] word_data,
    input  logic [ingress_pkg::bus_bytes-1:0] word_keep,
    input  logic                              word_last,
    input  logic                              pop,
    output logic [ingress_pkg::bus_width-1:0] head_data,
    output logic [ingress_pkg::bus_bytes-1:0] head_keep,
    output logic                              head_last,
    output logic                              pkt_ready,
    output logic                              commit_pulse,
    output logic                              drop_pulse
);

    import ingress_pkg::*;

    localparam int addr_bits  = $clog2(fifo_words);
    localparam int ptr_bits   = addr_bits + 1;
    localparam int entry_bits = 1 + bus_bytes + bus_width;

    logic [entry_bits-1:0] mem [fifo_words-1:0];

    logic [ptr_bits-1:0] spec_wr;
    logic [ptr_bits-1:0] commit_wr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits-1:0] fill;
    logic [ptr_bits-1:0] pkt_cnt;
    logic                sop;
    logic                skip;
    logic                accept;
    logic                full;
    logic                store;
    logic                overflow;
    logic                pkt_in;
    logic                pkt_out;

    //////////////////////////////
    // Write side

    // A packet is refused at its first word while the port is disabled
    assign accept   = word_valid && !skip && (enable || !sop);
    assign fill     = spec_wr - rd_ptr;
    assign full     = (fill == ptr_bits'(fifo_words));
    assign store    = accept && !full;
    assign overflow = accept && full;
    assign pkt_in   = store && word_last;
    assign pkt_out  = pop && head_last;

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            spec_wr      <= '0;
            commit_wr    <= '0;
            rd_ptr       <= '0;
            pkt_cnt      <= '0;
            sop          <= 1'b1;
            skip         <= 1'b0;
            commit_pulse <= 1'b0;
            drop_pulse   <= 1'b0;
        end else begin
            commit_pulse <= pkt_in;
            drop_pulse   <= overflow;
            if (word_valid) begin
                sop  <= word_last;
                // Skip the rest of a refused or overflowed packet
                skip <= (!accept || overflow) && !word_last;
            end
            if (overflow) begin
                spec_wr <= commit_wr;
            end else if (store) begin
                spec_wr <= spec_wr + 1'b1;
                if (word_last) begin
                    commit_wr <= spec_wr + 1'b1;
                end
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (pkt_in && !pkt_out) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end else if (!pkt_in && pkt_out) begin
                pkt_cnt <= pkt_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (store) begin
            mem[spec_wr[addr_bits-1:0]] <= {word_last, word_keep, word_data};
        end
    end

    //////////////////////////////
    // Read side

    assign {head_last, head_keep, head_data} = mem[rd_ptr[addr_bits-1:0]];
    assign pkt_ready = (pkt_cnt != '0);

endmodule

// File: hw/ingress_rr_arbiter.sv
/* Round-robin grant over the port buffers holding complete packets. The grant
   stays locked until the packet's last word is popped. */

`timescale 1ns/1ns

module ingress_rr_arbiter #(
    parameter int num_ports = 4,
    parameter int port_bits = 2
) (
    input  logic                 clk_ifc,
    input  logic                 rst_n,
    input  logic [num_ports-1:0] pkt_ready,
    input  logic                 take,
    input  logic [num_ports-1:0] head_last,
    output logic [port_bits-1:0] grant_port,
    output logic                 grant_valid,
    output logic [num_ports-1:0] pop
);

    logic                 found;
    logic [port_bits-1:0] next_port;

    // Search starts one past the port granted last
    always_comb begin
        int cand;
        found     = 1'b0;
        next_port = grant_port;
        for (int i = 1; i <= num_ports; i++) begin
            cand = (int'(grant_port) + i) % num_ports;
            if (!found && pkt_ready[cand]) begin
                found     = 1'b1;
                next_port = port_bits'(cand);
            end
        end
    end

    always_comb begin
        pop = '0;
        if (grant_valid && take) begin
            pop[grant_port] = 1'b1;
        end
    end

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            grant_valid <= 1'b0;
            grant_port  <= port_bits'(num_ports - 1);
        end else if (!grant_valid) begin
            if (found) begin
                grant_valid <= 1'b1;
                grant_port  <= next_port;
            end
        end else if (take && head_last[grant_port]) begin
            // Last word of the packet has left the buffer
            grant_valid <= 1'b0;
        end
    end

endmodule

// File: hw/ingress_output_stage.sv
/* One-word output register for the converged bus. Muxes the granted buffer head
   and tags the word with its port index in out_user. */

`timescale 1ns/1ns

module ingress_output_stage #(
    parameter int num_ports = 4,
    parameter int port_bits = 2
) (
    input  logic                              clk_ifc,
    input  logic                              rst_n,
    input  logic [port_bits-1:0]              grant_port,
    input  logic                              grant_valid,
    input  logic [ingress_pkg::bus_width-1:0] head_data [num_ports-1:0],
    input  logic [ingress_pkg::bus_bytes-1:0] head_keep [num_ports-1:0],
    input  logic [num_ports-1:0]              head_last,
    input  logic                              out_ready,
    output logic                              take,
    output logic                              out_valid,
    output logic [ingress_pkg::bus_width-1:0] out_data,
    output logic [ingress_pkg::bus_bytes-1:0] out_keep,
    output logic                              out_last,
    output logic [port_bits-1:0]              out_user
);

    // Load when empty or when the held word leaves this cycle
    assign take = grant_valid && (!out_valid || out_ready);

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (take) begin
            out_data <= head_data[grant_port];
            out_keep <= head_keep[grant_port];
            out_last <= head_last[grant_port];
            out_user <= grant_port;
        end
    end

endmodule

// File: hw/ingress_port_counters.sv
/* Per-port forwarded and dropped frame counters with sticky overflow flags.
   A clear bit zeroes that port's counts and flag. */

`timescale 1ns/1ns

module ingress_port_counters #(
    parameter int num_ports = 4
) (
    input  logic                              clk_ifc,
    input  logic                              rst_n,
    input  logic [num_ports-1:0]              commit_pulse,
    input  logic [num_ports-1:0]              drop_pulse,
    input  logic [num_ports-1:0]              cnts_clear,
    output logic [ingress_pkg::cnt_width-1:0] frame_cnt [num_ports-1:0],
    output logic [ingress_pkg::cnt_width-1:0] drop_cnt  [num_ports-1:0],
    output logic [num_ports-1:0]              buf_overflow
);

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt    <= '{default: '0};
            drop_cnt     <= '{default: '0};
            buf_overflow <= '0;
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (cnts_clear[p]) begin
                    frame_cnt[p]    <= '0;
                    drop_cnt[p]     <= '0;
                    buf_overflow[p] <= 1'b0;
                end else begin
                    if (commit_pulse[p]) begin
                        frame_cnt[p] <= frame_cnt[p] + 1'b1;
                    end
                    // Overflow flag stays set until cleared
                    if (drop_pulse[p]) begin
                        drop_cnt[p]     <= drop_cnt[p] + 1'b1;
                        buf_overflow[p] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: hw/router_ingress.sv
/* Packet router ingress stage. Widens and buffers each physical port, then merges
   complete packets round-robin onto one 64-bit bus tagged with the port index. */

`timescale 1ns/1ns

module router_ingress #(
    parameter int    num_8b_ports  = 2,
    parameter int    num_32b_ports = 2,
    parameter int    fifo_words    = 64,
    localparam int   num_ports     = num_8b_ports + num_32b_ports,
    localparam int   port_bits     = (num_ports > 1) ? $clog2(num_ports) : 1
) (
    input  logic                                  clk_ifc,
    input  logic                                  rst_n,
    input  logic [num_ports-1:0]                  ports_enable,
    input  logic [num_ports-1:0]                  cnts_clear,

    // 8-bit physical ports
    input  logic [num_8b_ports-1:0]               in_8b_valid,
    input  logic [ingress_pkg::port_8b_bytes*8-1:0] in_8b_data [num_8b_ports-1:0],
    input  logic [ingress_pkg::port_8b_bytes-1:0] in_8b_keep_last [num_8b_ports-1:0],
    input  logic [num_8b_ports-1:0]               in_8b_last,

    // 32-bit physical ports
    input  logic [num_32b_ports-1:0]              in_32b_valid,
    input  logic [ingress_pkg::port_32b_bytes*8-1:0] in_32b_data [num_32b_ports-1:0],
    input  logic [ingress_pkg::port_32b_bytes-1:0] in_32b_keep_last [num_32b_ports-1:0],
    input  logic [num_32b_ports-1:0]              in_32b_last,

    // Converged bus
    output logic                                  out_valid,
    output logic [ingress_pkg::bus_width-1:0]     out_data,
    output logic [ingress_pkg::bus_bytes-1:0]     out_keep,
    output logic                                  out_last,
    output logic [port_bits-1:0]                  out_user,
    input  logic                                  out_ready,

    // Statistics
    output logic [ingress_pkg::cnt_width-1:0]     frame_cnt [num_ports-1:0],
    output logic [ingress_pkg::cnt_width-1:0]     drop_cnt  [num_ports-1:0],
    output logic [num_ports-1:0]                  buf_overflow
);

    import ingress_pkg::*;

    logic [num_ports-1:0] word_valid;
    logic [bus_width-1:0] word_data [num_ports-1:0];
    logic [bus_bytes-1:0] word_keep [num_ports-1:0];
    logic [num_ports-1:0] word_last;

    logic [bus_width-1:0] head_data [num_ports-1:0];
    logic [bus_bytes-1:0] head_keep [num_ports-1:0];
    logic [num_ports-1:0] head_last;
    logic [num_ports-1:0] pkt_ready;
    logic [num_ports-1:0] commit_pulse;
    logic [num_ports-1:0] drop_pulse;
    logic [num_ports-1:0] pop;

    logic [port_bits-1:0] grant_port;
    logic                 grant_valid;
    logic                 take;

    //////////////////////////////
    // Per-port upsizing and buffering, 8-bit ports take the low indices

    for (genvar i = 0; i < num_8b_ports; i++) begin : g_port_8b
        ingress_width_upsizer #(
            .in_bytes     (port_8b_bytes)
        ) upsizer_inst (
            .clk_ifc      (clk_ifc),
            .rst_n        (rst_n),
            .in_valid     (in_8b_valid[i]),
            .in_data      (in_8b_data[i]),
            .in_keep_last (in_8b_keep_last[i]),
            .in_last      (in_8b_last[i]),
            .word_valid   (word_valid[i]),
            .word_data    (word_data[i]),
            .word_keep    (word_keep[i]),
            .word_last    (word_last[i])
        );

        ingress_pkt_fifo #(
            .fifo_words   (fifo_words)
        ) fifo_inst (
            .clk_ifc      (clk_ifc),
            .rst_n        (rst_n),
            .enable       (ports_enable[i]),
            .word_valid   (word_valid[i]),
            .word_data    (word_data[i]),
            .word_keep    (word_keep[i]),
            .word_last    (word_last[i]),
            .pop          (pop[i]),
            .head_data    (head_data[i]),
            .head_keep    (head_keep[i]),
            .head_last    (head_last[i]),
            .pkt_ready    (pkt_ready[i]),
            .commit_pulse (commit_pulse[i]),
            .drop_pulse   (drop_pulse[i])
        );
    end

    for (genvar i = 0; i < num_32b_ports; i++) begin : g_port_32b
        localparam int p = num_8b_ports + i;

        ingress_width_upsizer #(
            .in_bytes     (port_32b_bytes)
        ) upsizer_inst (
            .clk_ifc      (clk_ifc),
            .rst_n        (rst_n),
            .in_valid     (in_32b_valid[i]),
            .in_data      (in_32b_data[i]),
            .in_keep_last (in_32b_keep_last[i]),
            .in_last      (in_32b_last[i]),
            .word_valid   (word_valid[p]),
            .word_data    (word_data[p]),
            .word_keep    (word_keep[p]),
            .word_last    (word_last[p])
        );

        ingress_pkt_fifo #(
            .fifo_words   (fifo_words)
        ) fifo_inst (
            .clk_ifc      (clk_ifc),
            .rst_n        (rst_n),
            .enable       (ports_enable[p]),
            .word_valid   (word_valid[p]),
            .word_data    (word_data[p]),
            .word_keep    (word_keep[p]),
            .word_last    (word_last[p]),
            .pop          (pop[p]),
            .head_data    (head_data[p]),
            .head_keep    (head_keep[p]),
            .head_last    (head_last[p]),
            .pkt_ready    (pkt_ready[p]),
            .commit_pulse (commit_pulse[p]),
            .drop_pulse   (drop_pulse[p])
        );
    end

    //////////////////////////////
    // Merge onto the converged bus

    ingress_rr_arbiter #(
        .num_ports   (num_ports),
        .port_bits   (port_bits)
    ) arbiter_inst (
        .clk_ifc     (clk_ifc),
        .rst_n       (rst_n),
        .pkt_ready   (pkt_ready),
        .take        (take),
        .grant_port  (grant_port),
        .grant_valid (grant_valid),
        .pop         (pop),
        .head_last   (head_last)
    );

    ingress_output_stage #(
        .num_ports   (num_ports),
        .port_bits   (port_bits)
    ) output_stage_inst (
        .clk_ifc     (clk_ifc),
        .rst_n       (rst_n),
        .grant_port  (grant_port),
        .grant_valid (grant_valid),
        .head_data   (head_data),
        .head_keep   (head_keep),
        .head_last   (head_last),
        .out_ready   (out_ready),
        .take        (take),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_keep    (out_keep),
        .out_last    (out_last),
        .out_user    (out_user)
    );

    ingress_port_counters #(
        .num_ports    (num_ports)
    ) counters_inst (
        .clk_ifc      (clk_ifc),
        .rst_n        (rst_n),
        .commit_pulse (commit_pulse),
        .drop_pulse   (drop_pulse),
        .cnts_clear   (cnts_clear),
        .frame_cnt    (frame_cnt),
        .drop_cnt     (drop_cnt),
        .buf_overflow (buf_overflow)
    );

endmodule

// File: testbench/ingress_tb_model.svh
/* Packet model for the ingress testbench: stimulus tasks, per-port expected queues,
   converged-bus word checker and the value compare. Included inside the testbench module. */

`ifndef INGRESS_TB_MODEL_SVH
`define INGRESS_TB_MODEL_SVH

// Expected packets per port, kept as start byte and length
logic [7:0] exp_start  [num_ports][queue_depth];
int         exp_len    [num_ports][queue_depth];
int         q_wr       [num_ports];
int         q_rd       [num_ports];
int         exp_frames [num_ports];
int         exp_drops  [num_ports];
logic       exp_ovf    [num_ports];
int         pending;

// Port the next packet must come from, negative when any port may send
int         exp_port;

// Packet currently leaving on the converged bus
logic       mon_active;
logic       mon_unexpected;
int         mon_port;
int         mon_len;
int         mon_off;
logic [7:0] mon_start;

task automatic check_value(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (actual !== expected) begin
        $display("ERROR %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
        errors++;
    end
endtask

function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
endfunction

task automatic init_model();
    for (int p = 0; p < num_ports; p++) begin
        q_wr[p]       = 0;
        q_rd[p]       = 0;
        exp_frames[p] = 0;
        exp_drops[p]  = 0;
        exp_ovf[p]    = 1'b0;
    end
    pending        = 0;
    exp_port       = -1;
    mon_active     = 1'b0;
    mon_unexpected = 1'b0;
    mon_off        = 0;
endtask

task automatic push_expected(input int port, input logic [7:0] start, input int len);
    exp_start[port][q_wr[port] % queue_depth] = start;
    exp_len[port][q_wr[port] % queue_depth]   = len;
    q_wr[port]++;
    exp_frames[port]++;
    pending++;
endtask

task automatic drive_beat(input int port, input logic valid, input logic [31:0] data,
                          input logic [3:0] keep, input logic last);
    if (port < num_8b_ports) begin
        in_8b_valid[port]     = valid;
        in_8b_data[port]      = data[7:0];
        in_8b_keep_last[port] = keep[0];
        in_8b_last[port]      = last;
    end else begin
        in_32b_valid[port-num_8b_ports]     = valid;
        in_32b_data[port-num_8b_ports]      = data;
        in_32b_keep_last[port-num_8b_ports] = keep;
        in_32b_last[port-num_8b_ports]      = last;
    end
endtask

// Incrementing bytes from start, idle cycles mixed in at gap_pct percent
task automatic send_packet(input int port, input logic [7:0] start, input int len,
                           input int gap_pct);
    int          beat_bytes;
    int          beats;
    int          i;
    int          n;
    logic [31:0] data;
    logic [3:0]  keep;
    beat_bytes = (port < num_8b_ports) ? port_8b_bytes : port_32b_bytes;
    beats      = (len + beat_bytes - 1) / beat_bytes;
    i          = 0;
    while (i < beats) begin
        @(posedge clk_ifc);
        #2;
        if (gap_pct > 0 && rand_range(0, 99) < gap_pct) begin
            drive_beat(port, 1'b0, '0, '0, 1'b0);
        end else begin
            n    = (len - i * beat_bytes < beat_bytes) ? len - i * beat_bytes : beat_bytes;
            data = '0;
            keep = '0;
            for (int k = 0; k < n; k++) begin
                data[k*8 +: 8] = 8'(start + i * beat_bytes + k);
                keep[k]        = 1'b1;
            end
            drive_beat(port, 1'b1, data, keep, i == beats - 1);
            i++;
        end
    end
    @(posedge clk_ifc);
    #2;
    drive_beat(port, 1'b0, '0, '0, 1'b0);
endtask

task automatic send_stream(input int port, input int count, input int gap_pct);
    int         len;
    logic [7:0] start;
    for (int n = 0; n < count; n++) begin
        len   = (port < num_8b_ports) ? rand_range(1, 24) : rand_range(1, 80);
        start = 8'(rand_range(0, 255));
        push_expected(port, start, len);
        send_packet(port, start, len, gap_pct);
    end
endtask

// One word accepted on the converged bus
task automatic check_word();
    logic [63:0] exp_data;
    logic [63:0] mask;
    logic [7:0]  exp_keep;
    int          n;
    if (!mon_active) begin
        mon_active     = 1'b1;
        mon_off        = 0;
        mon_port       = int'(out_user);
        if (exp_port >= 0) begin
            check_value("out_user port", exp_port, out_user);
        end
        mon_unexpected = (q_rd[mon_port] == q_wr[mon_port]);
        if (mon_unexpected) begin
            $display("Packet from port %0d in %s was not expected by the model",
                     mon_port, test_name);
            errors++;
        end else begin
            mon_start = exp_start[mon_port][q_rd[mon_port] % queue_depth];
            mon_len   = exp_len[mon_port][q_rd[mon_port] % queue_depth];
            q_rd[mon_port]++;
        end
    end
    if (!mon_unexpected) begin
        n = mon_len - mon_off;
        if (n > bus_bytes) begin
            n = bus_bytes;
        end
        exp_data = '0;
        mask     = '0;
        exp_keep = '0;
        for (int k = 0; k < n; k++) begin
            exp_data[k*8 +: 8] = 8'(mon_start + mon_off + k);
            mask[k*8 +: 8]     = 8'hff;
            exp_keep[k]        = 1'b1;
        end
        check_value("out_user", mon_port, out_user);
        check_value("out_keep", exp_keep, out_keep);
        check_value("out_data", exp_data, out_data & mask);
        check_value("out_last", mon_off + bus_bytes >= mon_len, out_last);
    end
    mon_off = mon_off + bus_bytes;
    if (out_last) begin
        mon_active = 1'b0;
        if (!mon_unexpected) begin
            pending--;
        end
    end
endtask

task automatic check_counters();
    for (int p = 0; p < num_ports; p++) begin
        check_value($sformatf("frame_cnt[%0d]", p), exp_frames[p], frame_cnt[p]);
        check_value($sformatf("drop_cnt[%0d]", p), exp_drops[p], drop_cnt[p]);
        check_value($sformatf("buf_overflow[%0d]", p), exp_ovf[p], buf_overflow[p]);
    end
endtask

`endif

// File: testbench/ingress_tb.sv
/* Self-checking testbench for the router ingress stage. Sends random packets on
   all physical ports and checks the converged bus and counters against a model. */

`timescale 1ns/1ns

module ingress_tb;

    import ingress_pkg::*;

    localparam int num_8b_ports  = 2;
    localparam int num_32b_ports = 2;
    localparam int num_ports     = num_8b_ports + num_32b_ports;
    localparam int port_bits     = 2;
    localparam int fifo_words    = 64;
    localparam int queue_depth   = 64;
    localparam int drain_limit   = 20000;

    logic                     clk_ifc;
    logic                     rst_n;
    logic [num_ports-1:0]     ports_enable;
    logic [num_ports-1:0]     cnts_clear;
    logic [num_8b_ports-1:0]  in_8b_valid;
    logic [7:0]               in_8b_data       [num_8b_ports-1:0];
    logic [0:0]               in_8b_keep_last  [num_8b_ports-1:0];
    logic [num_8b_ports-1:0]  in_8b_last;
    logic [num_32b_ports-1:0] in_32b_valid;
    logic [31:0]              in_32b_data      [num_32b_ports-1:0];
    logic [3:0]               in_32b_keep_last [num_32b_ports-1:0];
    logic [num_32b_ports-1:0] in_32b_last;
    logic                     out_valid;
    logic [bus_width-1:0]     out_data;
    logic [bus_bytes-1:0]     out_keep;
    logic                     out_last;
    logic [port_bits-1:0]     out_user;
    logic                     out_ready;
    logic [cnt_width-1:0]     frame_cnt [num_ports-1:0];
    logic [cnt_width-1:0]     drop_cnt  [num_ports-1:0];
    logic [num_ports-1:0]     buf_overflow;

    // Run bookkeeping
    integer seed;
    string  test_name;
    int     errors;
    int     errors_at_start;
    int     tests_passed;
    int     tests_failed;
    logic   abort;
    logic   rand_ready;

    // Word held on the bus while out_ready is low
    logic                 stalled;
    logic [bus_width-1:0] held_data;
    logic [bus_bytes-1:0] held_keep;
    logic                 held_last;
    logic [port_bits-1:0] held_user;

    `include "ingress_tb_model.svh"

    router_ingress #(
        .num_8b_ports     (num_8b_ports),
        .num_32b_ports    (num_32b_ports),
        .fifo_words       (fifo_words)
    ) router_ingress_inst (
        .clk_ifc          (clk_ifc),
        .rst_n            (rst_n),
        .ports_enable     (ports_enable),
        .cnts_clear       (cnts_clear),
        .in_8b_valid      (in_8b_valid),
        .in_8b_data       (in_8b_data),
        .in_8b_keep_last  (in_8b_keep_last),
        .in_8b_last       (in_8b_last),
        .in_32b_valid     (in_32b_valid),
        .in_32b_data      (in_32b_data),
        .in_32b_keep_last (in_32b_keep_last),
        .in_32b_last      (in_32b_last),
        .out_valid        (out_valid),
        .out_data         (out_data),
        .out_keep         (out_keep),
        .out_last         (out_last),
        .out_user         (out_user),
        .out_ready        (out_ready),
        .frame_cnt        (frame_cnt),
        .drop_cnt         (drop_cnt),
        .buf_overflow     (buf_overflow)
    );

    initial clk_ifc = 1'b0;
    always #20 clk_ifc = ~clk_ifc;

    // Sink side, random stalls only while rand_ready is set
    always @(posedge clk_ifc) begin
        #2;
        out_ready = rand_ready ? (rand_range(0, 2) != 0) : 1'b1;
    end

    //////////////////////////////
    // Converged bus monitor

    always @(posedge clk_ifc) begin
        if (rst_n) begin
            if (stalled) begin
                check_value("out_valid held", 1, out_valid);
                check_value("out_data held", held_data, out_data);
                check_value("out_keep held", held_keep, out_keep);
                check_value("out_last held", held_last, out_last);
                check_value("out_user held", held_user, out_user);
            end
            if (out_valid && out_ready) begin
                check_word();
            end
            stalled   = out_valid && !out_ready;
            held_data = out_data;
            held_keep = out_keep;
            held_last = out_last;
            held_user = out_user;
        end
    end

    //////////////////////////////
    // Test sequencing

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        exp_port        = -1;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // Until every expected packet has left the bus
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (pending != 0 && !abort) begin
            @(posedge clk_ifc);
            #1;
            cycles++;
            if (cycles > drain_limit) begin
                $display("Timeout in %s: %0d packets never left the converged bus",
                         test_name, pending);
                errors++;
                abort = 1'b1;
            end
        end
    endtask

    task automatic run_in_turn();
        int         len;
        logic [7:0] start;
        start_test("in_turn");
        check_value("out_valid after reset", 0, out_valid);
        check_counters();
        for (int r = 0; r < 2; r++) begin
            for (int p = 0; p < num_ports; p++) begin
                // Odd lengths on narrow ports exercise a partial last word
                len   = (p < num_8b_ports) ? 2 * rand_range(0, 11) + 1 : rand_range(1, 80);
                start = 8'(rand_range(0, 255));
                exp_port = p;
                push_expected(p, start, len);
                send_packet(p, start, len, 0);
                wait_drain();
            end
        end
        exp_port = -1;
        check_counters();
        finish_test();
    endtask

    task automatic run_streams(input string name, input int count, input int gap_pct,
                               input logic stall);
        start_test(name);
        rand_ready = stall;
        fork
            send_stream(0, count, gap_pct);
            send_stream(1, count, gap_pct);
            send_stream(2, count, gap_pct);
            send_stream(3, count, gap_pct);
        join
        wait_drain();
        rand_ready = 1'b0;
        check_counters();
        finish_test();
    endtask

    task automatic run_overflow();
        start_test("overflow");
        exp_port = num_8b_ports;
        // Longer than the buffer, so it can never commit
        send_packet(num_8b_ports, 8'h40, fifo_words * bus_bytes + 40, 0);
        exp_drops[num_8b_ports]++;
        exp_ovf[num_8b_ports] = 1'b1;
        push_expected(num_8b_ports, 8'h90, 20);
        send_packet(num_8b_ports, 8'h90, 20, 0);
        wait_drain();
        check_counters();
        finish_test();
    endtask

    task automatic run_disable_clear();
        int cycles;
        start_test("disable_clear");
        exp_port = 1;
        @(posedge clk_ifc);
        #2;
        ports_enable[1] = 1'b0;
        send_packet(1, 8'h80, 13, 0);
        repeat (4) @(posedge clk_ifc);
        #2;
        ports_enable[1] = 1'b1;
        push_expected(1, 8'h20, 11);
        send_packet(1, 8'h20, 11, 0);
        wait_drain();
        check_counters();
        @(posedge clk_ifc);
        #2;
        cnts_clear[num_8b_ports] = 1'b1;
        @(posedge clk_ifc);
        #2;
        cnts_clear[num_8b_ports] = 1'b0;
        exp_frames[num_8b_ports] = 0;
        exp_drops[num_8b_ports]  = 0;
        exp_ovf[num_8b_ports]    = 1'b0;
        cycles = 0;
        while ((frame_cnt[num_8b_ports] != 0 || drop_cnt[num_8b_ports] != 0 ||
                buf_overflow[num_8b_ports]) && cycles < 8) begin
            @(posedge clk_ifc);
            #1;
            cycles++;
        end
        check_counters();
        finish_test();
    endtask

    initial begin
        seed         = 32'he362;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        abort        = 1'b0;
        rand_ready   = 1'b0;
        stalled      = 1'b0;
        test_name    = "reset";
        rst_n        = 1'b0;
        out_ready    = 1'b1;
        ports_enable = '1;
        cnts_clear   = '0;
        for (int p = 0; p < num_ports; p++) begin
            drive_beat(p, 1'b0, '0, '0, 1'b0);
        end
        init_model();
        repeat (16) @(posedge clk_ifc);
        #2;
        rst_n = 1'b1;

        run_in_turn();
        run_streams("all_ports", 6, 30, 1'b0);
        run_streams("backpressure", 4, 50, 1'b1);
        run_overflow();
        run_disable_clear();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+testbench
hw/ingress_pkg.sv
hw/ingress_width_upsizer.sv
hw/ingress_pkt_fifo.sv
hw/ingress_rr_arbiter.sv
hw/ingress_output_stage.sv
hw/ingress_port_counters.sv
hw/router_ingress.sv
testbench/ingress_tb.sv
